//--- source/ps2_settings.svh
// PS/2 receiver build settings
`ifndef PS2_SETTINGS_SVH
`define PS2_SETTINGS_SVH

// ------------------------------------------------------------
// frame layout
// ------------------------------------------------------------
`define PS2_FRAME_BITS 11        // start, 8 data, parity, stop

// ------------------------------------------------------------
// idle watchdog, 60 us at 25 MHz
// ------------------------------------------------------------
`define PS2_WATCHDOG_CYCLES 1500 // clk cycles of quiet high clock
`define PS2_WATCHDOG_BITS 11     // wide enough for the count above

// shift key events set no data-ready when this is 1
`define PS2_TRAP_SHIFT_KEYS 1

`endif

//--- source/ps2_frame_pkg.sv
// PS/2 serial frame types
`include "ps2_settings.svh"

package ps2_frame_pkg;

  // raw shift register contents
  // bit 0 is the start bit once a full frame is in
  // bits 8..1 hold the data byte, LSB first on the wire
  // bit 9 is parity, bit 10 the stop bit
  typedef logic [`PS2_FRAME_BITS-1:0] frame_t;

  // counts falling PS/2 clock edges within a frame
  // needs to reach PS2_FRAME_BITS, so 4 bits
  typedef logic [3:0] bit_count_t;

endpackage

//--- source/ps2_key_pkg.sv
// PS/2 key code types and constants
package ps2_key_pkg;

  // ------------------------------------------------------------
  // data types
  // ------------------------------------------------------------
  typedef logic [7:0] scan_code_t;  // one byte from the keyboard
  typedef logic [7:0] ascii_t;      // translated character

  // ------------------------------------------------------------
  // special codes of scan code set 2
  // ------------------------------------------------------------

  // prefix codes, these never produce output on their own
  localparam scan_code_t EXTEND_CODE  = 8'he0;  // extended key follows
  localparam scan_code_t RELEASE_CODE = 8'hf0;  // key up follows

  // the two shift keys, tracked by the decoder
  localparam scan_code_t LEFT_SHIFT_CODE  = 8'h12;
  localparam scan_code_t RIGHT_SHIFT_CODE = 8'h59;

endpackage

//--- source/ps2_frame_if.sv
// PS/2 frame bus between receive stages
`timescale 1ns/1ps

interface ps2_frame_if;
  import ps2_key_pkg::*;

  logic       sample;          // one cycle per falling ps2 clock edge
  logic       data_bit;        // synchronized data line
  logic       watchdog_clear;  // idle timeout, drop partial frame
  logic       frame_done;      // full frame present this cycle
  scan_code_t scan_code;       // data byte of the frame

  // clock follower produces the bit strobes
  modport clock_side (output sample, output data_bit, output watchdog_clear);

  // shifter turns strobes into frames
  modport shift_side (input sample, input data_bit, input watchdog_clear,
                      output frame_done, output scan_code);

  // decoder only sees finished frames
  modport key_side (input frame_done, input scan_code);

endinterface

//--- source/ps2_clock_fsm.sv
// PS/2 clock follower
`timescale 1ns/1ps

module ps2_clock_fsm (
  input  logic clk,
  input  logic reset,
  input  logic ps2_clk,
  input  logic ps2_data,
  output logic timer_enable,
  input  logic timer_expired,
  ps2_frame_if.clock_side frame
);

  typedef enum logic [1:0] {
    CLK_HIGH,   // idle or between bits
    FALL_MARK,  // one cycle after a falling edge
    CLK_LOW,
    RISE_MARK   // one cycle after a rising edge
  } state_t;

  logic   ps2_clk_s;      // lines registered once into clk domain
  logic   ps2_data_s;
  state_t state;
  state_t next_state;
  logic   watchdog_done;  // one clear per idle stretch

  always_ff @(posedge clk)
  begin
    ps2_clk_s  <= ps2_clk;
    ps2_data_s <= ps2_data;
  end

  // reset parks in the rising marker, timer starts from zero
  always_ff @(posedge clk)
  begin
    if (reset)
      state <= RISE_MARK;
    else
      state <= next_state;
  end

  always_comb
  begin
    next_state = state;
    case (state)
      CLK_HIGH:
        if (!ps2_clk_s)
          next_state = FALL_MARK;
      FALL_MARK: next_state = CLK_LOW;
      CLK_LOW:
        if (ps2_clk_s)
          next_state = RISE_MARK;
      default:   next_state = CLK_HIGH;  // rising marker
    endcase
  end

  // ------------------------------------------------------------
  // strobes to the shifter and timer control
  // ------------------------------------------------------------
  assign timer_enable   = (state == CLK_HIGH) || (state == CLK_LOW);
  assign frame.sample   = (state == FALL_MARK);
  assign frame.data_bit = ps2_data_s;
  assign frame.watchdog_clear = (state == CLK_HIGH) && timer_expired &&
                                ps2_clk_s && !watchdog_done;

  // timer stays saturated, so remember the clear was sent
  always_ff @(posedge clk)
  begin
    if (reset || state != CLK_HIGH)
      watchdog_done <= 1'b0;
    else if (frame.watchdog_clear)
      watchdog_done <= 1'b1;
  end

  a_sample_single: assert property (@(posedge clk) disable iff (reset)
    frame.sample |=> !frame.sample);

endmodule

//--- source/ps2_watchdog_timer.sv
// PS/2 idle watchdog
`timescale 1ns/1ps
`include "ps2_settings.svh"

module ps2_watchdog_timer (
  input  logic clk,
  input  logic enable,   // held low for a cycle at each ps2 clock edge
  output logic expired
);

  localparam logic [`PS2_WATCHDOG_BITS-1:0] LAST_COUNT =
    `PS2_WATCHDOG_BITS'(`PS2_WATCHDOG_CYCLES - 1);

  logic [`PS2_WATCHDOG_BITS-1:0] count;

  // saturating up counter, restarts whenever enable drops
  always_ff @(posedge clk)
  begin
    if (!enable)
      count <= '0;
    else if (!expired)
      count <= count + 1'b1;  // stop at the terminal value
  end

  assign expired = (count == LAST_COUNT);

  // counter must saturate and never wrap past the terminal value
  a_count_saturates: assert property (@(posedge clk)
    enable |=> count <= LAST_COUNT);

endmodule

//--- source/ps2_frame_shifter.sv
// PS/2 frame shift register
`timescale 1ns/1ps
`include "ps2_settings.svh"

module ps2_frame_shifter (
  input  logic clk,
  input  logic reset,
  ps2_frame_if.shift_side frame
);
  import ps2_frame_pkg::*;

  localparam bit_count_t LAST_BIT = bit_count_t'(`PS2_FRAME_BITS);

  frame_t     shift_reg;  // bits arrive LSB first and enter at the top
  bit_count_t bit_count;

  // ------------------------------------------------------------
  // bit counter
  // ------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset)
      bit_count <= '0;
    else if (frame.frame_done || frame.watchdog_clear)
      bit_count <= '0;                   // frame finished or abandoned
    else if (frame.sample)
      bit_count <= bit_count + 1'b1;
  end

  // one line bit shifts in on each sample
  always_ff @(posedge clk)
  begin
    if (frame.sample)
      shift_reg <= {frame.data_bit, shift_reg[`PS2_FRAME_BITS-1:1]};
  end

  // high for the single cycle after the last sample
  assign frame.frame_done = (bit_count == LAST_BIT);

  // data byte sits between start bit and parity
  assign frame.scan_code = shift_reg[8:1];

  // sample strobes must never run the count past a full frame
  a_count_bound: assert property (@(posedge clk) disable iff (reset)
    bit_count <= LAST_BIT);

endmodule

//--- source/ps2_ascii_map.sv
// Scan code to ASCII table
`timescale 1ns/1ps

module ps2_ascii_map (
  input  ps2_key_pkg::scan_code_t scan_code,
  input  logic                    shift,
  output ps2_key_pkg::ascii_t     ascii
);
  import ps2_key_pkg::*;

  ascii_t base;       // unshifted character
  logic   is_letter;

  always_comb
  begin
    case (scan_code)
      8'h1c: base = 8'h61;  // a
      8'h32: base = 8'h62;  // b
      8'h21: base = 8'h63;  // c
      8'h23: base = 8'h64;  // d
      8'h24: base = 8'h65;  // e
      8'h2b: base = 8'h66;  // f
      8'h34: base = 8'h67;  // g
      8'h33: base = 8'h68;  // h
      8'h43: base = 8'h69;  // i
      8'h3b: base = 8'h6a;  // j
      8'h42: base = 8'h6b;  // k
      8'h4b: base = 8'h6c;  // l
      8'h3a: base = 8'h6d;  // m
      8'h31: base = 8'h6e;  // n
      8'h44: base = 8'h6f;  // o
      8'h4d: base = 8'h70;  // p
      8'h15: base = 8'h71;  // q
      8'h2d: base = 8'h72;  // r
      8'h1b: base = 8'h73;  // s
      8'h2c: base = 8'h74;  // t
      8'h3c: base = 8'h75;  // u
      8'h2a: base = 8'h76;  // v
      8'h1d: base = 8'h77;  // w
      8'h22: base = 8'h78;  // x
      8'h35: base = 8'h79;  // y
      8'h1a: base = 8'h7a;  // z
      8'h45: base = 8'h30;  // 0, digits ignore shift
      8'h16: base = 8'h31;
      8'h1e: base = 8'h32;
      8'h26: base = 8'h33;
      8'h25: base = 8'h34;
      8'h2e: base = 8'h35;
      8'h36: base = 8'h36;
      8'h3d: base = 8'h37;
      8'h3e: base = 8'h38;
      8'h46: base = 8'h39;  // 9
      8'h29: base = 8'h20;  // space
      8'h5a: base = 8'h0d;  // enter
      8'h66: base = 8'h08;  // backspace
      8'h0d: base = 8'h09;  // tab
      8'h76: base = 8'h1b;  // escape
      default: base = 8'h2e;  // '.' for anything unlisted
    endcase
  end

  // only a..z take the shift, upper case sits 20h lower
  assign is_letter = (base >= 8'h61) && (base <= 8'h7a);
  assign ascii     = (shift && is_letter) ? base - 8'h20 : base;

endmodule

//--- source/ps2_key_decoder.sv
// PS/2 key code decoder
`timescale 1ns/1ps
`include "ps2_settings.svh"

module ps2_key_decoder (
  input  logic clk,
  input  logic reset,
  ps2_frame_if.key_side frame,
  input  logic rx_read,
  output logic rx_extended,
  output logic rx_released,
  output logic rx_shift_key_on,
  output ps2_key_pkg::scan_code_t rx_scan_code,
  output ps2_key_pkg::ascii_t rx_ascii,
  output logic rx_data_ready
);
  import ps2_key_pkg::*;

  logic   is_extend;
  logic   is_release;
  logic   is_left_shift;
  logic   is_right_shift;
  logic   key_event;      // any non-prefix frame, clears the holds
  logic   output_strobe;  // key event that reaches the host
  logic   hold_extended;
  logic   hold_released;
  logic   left_shift_on;
  logic   right_shift_on;
  ascii_t ascii;

  assign is_extend      = (frame.scan_code == EXTEND_CODE);
  assign is_release     = (frame.scan_code == RELEASE_CODE);
  assign is_left_shift  = (frame.scan_code == LEFT_SHIFT_CODE);
  assign is_right_shift = (frame.scan_code == RIGHT_SHIFT_CODE);

  assign key_event     = frame.frame_done && !is_extend && !is_release;
  assign output_strobe = key_event && ((`PS2_TRAP_SHIFT_KEYS == 0) ||
                                       !(is_left_shift || is_right_shift));

  // ------------------------------------------------------------
  // prefix holds and shift state
  // ------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset || key_event)
    begin
      hold_extended <= 1'b0;
      hold_released <= 1'b0;
    end
    else if (frame.frame_done)
    begin
      hold_extended <= hold_extended | is_extend;
      hold_released <= hold_released | is_release;
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      left_shift_on  <= 1'b0;
      right_shift_on <= 1'b0;
    end
    else if (frame.frame_done)
    begin
      if (is_left_shift)
        left_shift_on <= !hold_released;   // make or break
      if (is_right_shift)
        right_shift_on <= !hold_released;
    end
  end

  assign rx_shift_key_on = left_shift_on || right_shift_on;

  ps2_ascii_map u_ascii_map (
    .scan_code (frame.scan_code),
    .shift     (rx_shift_key_on),
    .ascii     (ascii)
  );

  // ------------------------------------------------------------
  // host side registers
  // ------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      rx_extended  <= 1'b0;
      rx_released  <= 1'b0;
      rx_scan_code <= '0;
      rx_ascii     <= '0;
    end
    else if (output_strobe)
    begin
      rx_extended  <= hold_extended;
      rx_released  <= hold_released;
      rx_scan_code <= frame.scan_code;
      rx_ascii     <= ascii;
    end
  end

  // new key wins over a read in the same cycle, no buffering
  always_ff @(posedge clk)
  begin
    if (reset)
      rx_data_ready <= 1'b0;
    else if (output_strobe)
      rx_data_ready <= 1'b1;
    else if (rx_read)
      rx_data_ready <= 1'b0;
  end

  a_ready_needs_read: assert property (@(posedge clk) disable iff (reset)
    $fell(rx_data_ready) |-> $past(rx_read));

endmodule

//--- source/ps2_keyboard_rx.sv
// PS/2 keyboard receiver top
`timescale 1ns/1ps

module ps2_keyboard_rx (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    ps2_clk,
  input  logic                    ps2_data,
  output logic                    rx_extended,
  output logic                    rx_released,
  output logic                    rx_shift_key_on,
  output ps2_key_pkg::scan_code_t rx_scan_code,
  output ps2_key_pkg::ascii_t     rx_ascii,
  output logic                    rx_data_ready,
  input  logic                    rx_read
);

  logic timer_enable;   // follower in a steady clock state
  logic timer_expired;  // idle for the full watchdog time

  ps2_frame_if u_frame_if ();

  // ------------------------------------------------------------
  // line follower and its idle timer
  // ------------------------------------------------------------
  ps2_clock_fsm u_clock_fsm (
    .clk           (clk),
    .reset         (reset),
    .ps2_clk       (ps2_clk),
    .ps2_data      (ps2_data),
    .timer_enable  (timer_enable),
    .timer_expired (timer_expired),
    .frame         (u_frame_if.clock_side)
  );

  ps2_watchdog_timer u_watchdog_timer (
    .clk     (clk),
    .enable  (timer_enable),
    .expired (timer_expired)
  );

  // ------------------------------------------------------------
  // frame assembly and key decode
  // ------------------------------------------------------------
  ps2_frame_shifter u_frame_shifter (
    .clk   (clk),
    .reset (reset),
    .frame (u_frame_if.shift_side)
  );

  ps2_key_decoder u_key_decoder (
    .clk             (clk),
    .reset           (reset),
    .frame           (u_frame_if.key_side),
    .rx_read         (rx_read),
    .rx_extended     (rx_extended),
    .rx_released     (rx_released),
    .rx_shift_key_on (rx_shift_key_on),
    .rx_scan_code    (rx_scan_code),
    .rx_ascii        (rx_ascii),
    .rx_data_ready   (rx_data_ready)
  );

endmodule

//--- testbench/tb_clock_gen.sv
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic reset
);

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  // reset held for five rising edges, released on a falling edge
  initial
  begin
    reset = 1'b1;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  end

endmodule

//--- testbench/tb_ps2_keyboard.sv
// PS/2 keyboard receiver testbench
`timescale 1ns/1ps

module tb_ps2_keyboard;

  localparam int HALF_BIT_CYCLES = 20;  // one ps2 clock phase
  localparam int FRAME_COUNT     = 47;  // frames sent over all tests
  localparam int RUN_LIMIT       = FRAME_COUNT * 11 * 40 + 5000;

  // set 2 letter codes a..z and digit codes 0..9
  localparam logic [7:0] LETTER_CODES [26] = '{8'h1c, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2b,
    8'h34, 8'h33, 8'h43, 8'h3b, 8'h42, 8'h4b, 8'h3a, 8'h31, 8'h44, 8'h4d, 8'h15, 8'h2d,
    8'h1b, 8'h2c, 8'h3c, 8'h2a, 8'h1d, 8'h22, 8'h35, 8'h1a};
  localparam logic [7:0] DIGIT_CODES [10] = '{8'h45, 8'h16, 8'h1e, 8'h26, 8'h25, 8'h2e,
    8'h36, 8'h3d, 8'h3e, 8'h46};

  logic       clk;
  logic       reset;
  logic       ps2_clk;
  logic       ps2_data;
  logic       rx_read;
  logic       rx_extended;
  logic       rx_released;
  logic       rx_shift_key_on;
  logic [7:0] rx_scan_code;
  logic [7:0] rx_ascii;
  logic       rx_data_ready;
  int         errors = 0;
  int         checks = 0;
  logic [31:0] lcg_state = 32'd60;

  tb_clock_gen u_clock_gen (.clk(clk), .reset(reset));

  ps2_keyboard_rx u_dut (
    .clk             (clk),
    .reset           (reset),
    .ps2_clk         (ps2_clk),
    .ps2_data        (ps2_data),
    .rx_extended     (rx_extended),
    .rx_released     (rx_released),
    .rx_shift_key_on (rx_shift_key_on),
    .rx_scan_code    (rx_scan_code),
    .rx_ascii        (rx_ascii),
    .rx_data_ready   (rx_data_ready),
    .rx_read         (rx_read)
  );

  // ------------------------------------------------------------
  // reference model and helpers
  // ------------------------------------------------------------
  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic [7:0] expected_ascii(input logic [7:0] code, input logic shift);
    logic [7:0] result;
    result = 8'h2e;  // unlisted codes
    for (int i = 0; i < 26; i++)
      if (code == LETTER_CODES[i])
        result = (shift ? 8'h41 : 8'h61) + 8'(i);
    for (int i = 0; i < 10; i++)
      if (code == DIGIT_CODES[i])
        result = 8'h30 + 8'(i);
    case (code)
      8'h29: result = 8'h20;  // space
      8'h5a: result = 8'h0d;  // enter
      8'h66: result = 8'h08;  // backspace
      8'h0d: result = 8'h09;  // tab
      8'h76: result = 8'h1b;  // escape
      default: ;
    endcase
    return result;
  endfunction

  task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
    checks++;
    assert (got === exp)
    else
    begin
      errors++;
      $display("Fail %s: expected %h, got %h", name, exp, got);
    end
  endtask

  // bits go out LSB first, data changes while the ps2 clock is high
  task automatic send_bits(input logic [10:0] bits, input int count);
    for (int i = 0; i < count; i++)
    begin
      @(negedge clk);
      ps2_data = bits[i];
      repeat (HALF_BIT_CYCLES) @(negedge clk);
      ps2_clk = 1'b0;                           // keyboard pulls clock low
      repeat (HALF_BIT_CYCLES) @(negedge clk);
      ps2_clk = 1'b1;
    end
  endtask

  task automatic send_frame(input logic [7:0] code);
    send_bits({1'b1, ~^code, code, 1'b0}, 11);  // stop, odd parity, data, start
  endtask

  task automatic wait_ready();
    int waited;
    waited = 0;
    while (!rx_data_ready && waited < 100)
    begin
      @(negedge clk);
      waited++;
    end
    checks++;
    assert (rx_data_ready)
    else
    begin
      errors++;
      $display("rx_data_ready never rose after a key frame");
    end
  endtask

  task automatic check_key(input logic [7:0] code, input logic ext, input logic rel,
                           input logic [7:0] ascii);
    wait_ready();
    check_value("rx_scan_code", rx_scan_code, code);
    check_value("rx_ascii", rx_ascii, ascii);
    check_value("rx_extended", 8'(rx_extended), 8'(ext));
    check_value("rx_released", 8'(rx_released), 8'(rel));
  endtask

  task automatic read_key();
    @(negedge clk);
    rx_read = 1'b1;  // one cycle strobe
    @(negedge clk);
    rx_read = 1'b0;
    check_value("rx_data_ready", 8'(rx_data_ready), 8'h00);
  endtask

  // ------------------------------------------------------------
  // directed tests
  // ------------------------------------------------------------
  task automatic test_plain_keys();
    logic [7:0] codes [5];
    codes = '{8'h1c, 8'h32, 8'h21, 8'h16, 8'h45};
    foreach (codes[i])
    begin
      send_frame(codes[i]);
      check_key(codes[i], 1'b0, 1'b0, expected_ascii(codes[i], 1'b0));
      read_key();
    end
  endtask

  task automatic test_prefixes();
    send_frame(8'he0);
    check_value("rx_data_ready", 8'(rx_data_ready), 8'h00);  // prefix alone
    send_frame(8'h75);
    check_key(8'h75, 1'b1, 1'b0, 8'h2e);
    read_key();
    send_frame(8'hf0);
    check_value("rx_data_ready", 8'(rx_data_ready), 8'h00);
    send_frame(8'h1c);
    check_key(8'h1c, 1'b0, 1'b1, 8'h61);
    read_key();
    send_frame(8'he0);
    send_frame(8'hf0);
    check_value("rx_data_ready", 8'(rx_data_ready), 8'h00);
    send_frame(8'h75);
    check_key(8'h75, 1'b1, 1'b1, 8'h2e);
    read_key();
    send_frame(8'h32);  // holds must be gone now
    check_key(8'h32, 1'b0, 1'b0, 8'h62);
    read_key();
  endtask

  task automatic test_shift(input logic [7:0] shift_code);
    send_frame(shift_code);
    check_value("rx_shift_key_on", 8'(rx_shift_key_on), 8'h01);
    check_value("rx_data_ready", 8'(rx_data_ready), 8'h00);  // trapped
    send_frame(8'h1c);
    check_key(8'h1c, 1'b0, 1'b0, 8'h41);
    read_key();
    send_frame(8'hf0);
    send_frame(shift_code);  // shift released
    check_value("rx_shift_key_on", 8'(rx_shift_key_on), 8'h00);
    check_value("rx_data_ready", 8'(rx_data_ready), 8'h00);
    send_frame(8'h1c);
    check_key(8'h1c, 1'b0, 1'b0, 8'h61);
    read_key();
  endtask

  task automatic test_random_codes();
    logic [7:0] code;
    for (int n = 0; n < 20; n++)
    begin
      do
      begin
        lcg_state = lcg_next(lcg_state);
        code      = lcg_state[23:16];  // upper bits mix better
      end
      while (code == 8'he0 || code == 8'hf0 || code == 8'h12 || code == 8'h59);
      send_frame(code);
      check_key(code, 1'b0, 1'b0, expected_ascii(code, 1'b0));
      read_key();
    end
  endtask

  task automatic test_watchdog();
    send_bits(11'h7fe, 5);               // start and four data bits, then stall
    repeat (2000) @(negedge clk);        // clock idles high past the timeout
    send_frame(8'h2b);
    check_key(8'h2b, 1'b0, 1'b0, 8'h66);
    read_key();
  endtask

  task automatic test_overwrite();
    send_frame(8'h1c);
    wait_ready();
    send_frame(8'h32);                   // no read in between
    check_value("rx_data_ready", 8'(rx_data_ready), 8'h01);
    check_key(8'h32, 1'b0, 1'b0, 8'h62);
    read_key();
  endtask

  // ------------------------------------------------------------
  // run control
  // ------------------------------------------------------------
  initial
  begin
    repeat (RUN_LIMIT) @(posedge clk);
    $display("timeout: tests did not complete within %0d cycles", RUN_LIMIT);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial
  begin
    ps2_clk  = 1'b1;  // idle lines
    ps2_data = 1'b1;
    rx_read  = 1'b0;
    wait (!reset);
    @(negedge clk);
    test_plain_keys();
    test_prefixes();
    test_shift(8'h12);
    test_shift(8'h59);
    test_random_codes();
    test_watchdog();
    test_overwrite();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

//--- all.f
+incdir+source
source/ps2_frame_pkg.sv
source/ps2_key_pkg.sv
source/ps2_frame_if.sv
source/ps2_clock_fsm.sv
source/ps2_watchdog_timer.sv
source/ps2_frame_shifter.sv
source/ps2_ascii_map.sv
source/ps2_key_decoder.sv
source/ps2_keyboard_rx.sv
testbench/tb_clock_gen.sv
testbench/tb_ps2_keyboard.sv
